// ==== src/axil_pkg.sv ====
package axil_pkg;

	////////////////////////////////////////
	// AXI4-Lite channel definitions
	////////////////////////////////////////

	localparam int AXIL_ADDR_W = 6; // Byte address width

	typedef enum logic [1:0] {
		OKAY   = 2'b00,
		EXOKAY = 2'b01,
		SLVERR = 2'b10,
		DECERR = 2'b11
	} axil_resp_e;

	typedef struct packed {
		logic [AXIL_ADDR_W-1:0] addr;
		logic [2:0]             prot;
	} axil_aw_t;

	typedef struct packed {
		logic [31:0] data;
		logic [3:0]  strb;
	} axil_w_t;

	typedef struct packed {
		axil_resp_e resp;
	} axil_b_t;

	typedef struct packed {
		logic [31:0] data;
		axil_resp_e  resp;
	} axil_r_t;

	typedef struct packed {
		logic [AXIL_ADDR_W-1:0] addr;
		logic [2:0]             prot;
	} axil_ar_t;

endpackage

// ==== src/scratch_pkg.sv ====
package scratch_pkg;

	////////////////////////////////////////
	// Scratchpad memory request
	////////////////////////////////////////

	localparam int SCR_DATA_W = 16; // Memory word width
	localparam int SCR_BE_W   = 2;  // One enable per byte

	typedef enum logic {
		SCR_READ  = 1'b0,
		SCR_WRITE = 1'b1
	} scr_op_e;

	// Index is sized for the largest supported depth of 16 words
	typedef struct packed {
		scr_op_e               op;
		logic [3:0]            idx;
		logic [SCR_BE_W-1:0]   be;
		logic [SCR_DATA_W-1:0] wdata;
	} scr_req_t;

endpackage

// ==== src/scratch_ram.sv ====
`timescale 1ns/1ps

module scratch_ram import scratch_pkg::*; #(
	parameter int DEPTH = 16
) (
	input  logic                  PORT_A_CLK,
	input  logic                  PORT_A_RD_ARST,
	input  logic                  mem_valid,
	input  scr_req_t              mem_req,
	output logic [SCR_DATA_W-1:0] rd_data
);

	localparam int IDX_W  = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int BYTE_W = SCR_DATA_W / SCR_BE_W;

	logic [SCR_DATA_W-1:0] mem [DEPTH];
	logic [IDX_W-1:0]      idx;
	logic                  wr_en;
	logic                  rd_en;

	assign idx   = mem_req.idx[IDX_W-1:0];
	assign wr_en = mem_valid && (mem_req.op == SCR_WRITE);
	assign rd_en = mem_valid && (mem_req.op == SCR_READ);

	////////////////////////////////////////
	// Storage
	////////////////////////////////////////

	always_ff @(posedge PORT_A_CLK) begin
		if (wr_en) begin
			for (int b = 0; b < SCR_BE_W; b++) begin
				if (mem_req.be[b]) begin
					mem[idx][b*BYTE_W +: BYTE_W] <= mem_req.wdata[b*BYTE_W +: BYTE_W];
				end
			end
		end
	end

	// Read register holds its value between reads
	always_ff @(posedge PORT_A_CLK) begin
		if (PORT_A_RD_ARST) begin
			rd_data <= '0;
		end else if (rd_en) begin
			rd_data <= mem[idx]; // Valid the cycle after the grant
		end
	end

	// Ports wrap the address, so an index past the array means a broken front end
	idx_in_range: assert property (@(posedge PORT_A_CLK) disable iff (PORT_A_RD_ARST)
		mem_valid |-> (mem_req.idx < DEPTH));

endmodule

// ==== src/scratch_arbiter.sv ====
`timescale 1ns/1ps

module scratch_arbiter import scratch_pkg::*; (
	input  logic       PORT_A_CLK,
	input  logic       PORT_A_RD_ARST,
	input  logic [1:0] req_valid,
	input  scr_req_t   req0,
	input  scr_req_t   req1,
	output logic [1:0] gnt,
	output logic       mem_valid,
	output scr_req_t   mem_req
);

	logic last_gnt; // Port granted most recently

	////////////////////////////////////////
	// Round-robin grant
	////////////////////////////////////////

	always_comb begin
		case (req_valid)
			2'b01:   gnt = 2'b01;
			2'b10:   gnt = 2'b10;
			2'b11:   gnt = last_gnt ? 2'b01 : 2'b10; // Other port wins
			default: gnt = 2'b00;
		endcase
	end

	always_ff @(posedge PORT_A_CLK) begin
		if (PORT_A_RD_ARST) begin
			last_gnt <= 1'b1; // Port 0 first after reset
		end else if (|gnt) begin
			last_gnt <= gnt[1];
		end
	end

	////////////////////////////////////////
	// Request mux to the RAM
	////////////////////////////////////////

	assign mem_valid = |gnt;
	assign mem_req   = gnt[1] ? req1 : req0;

	gnt_onehot: assert property (@(posedge PORT_A_CLK) disable iff (PORT_A_RD_ARST)
		$onehot0(gnt));

	gnt_requested: assert property (@(posedge PORT_A_CLK) disable iff (PORT_A_RD_ARST)
		(gnt & ~req_valid) == 2'b00);

endmodule

// ==== src/axil_scratch_port.sv ====
`timescale 1ns/1ps

module axil_scratch_port import axil_pkg::*, scratch_pkg::*; #(
	parameter int DEPTH = 16
) (
	input  logic                  PORT_A_CLK,
	input  logic                  PORT_A_RD_ARST,
	input  logic                  awvalid,
	output logic                  awready,
	input  axil_aw_t              aw,
	input  logic                  wvalid,
	output logic                  wready,
	input  axil_w_t               w,
	output logic                  bvalid,
	input  logic                  bready,
	output axil_b_t               b,
	input  logic                  arvalid,
	output logic                  arready,
	input  axil_ar_t              ar,
	output logic                  rvalid,
	input  logic                  rready,
	output axil_r_t               r,
	output logic                  req_valid,
	output scr_req_t              req,
	input  logic                  gnt,
	input  logic [SCR_DATA_W-1:0] rd_data
);

	localparam int IDX_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	typedef enum logic [2:0] {
		IDLE, REQ_WRITE, REQ_READ, READ_DATA, WRITE_RESP, READ_RESP
	} state_e;

	state_e                state;
	axil_aw_t              aw_q;
	axil_w_t               w_q;
	logic                  aw_held, w_held;
	logic                  aw_take, w_take, ar_take;
	logic                  aw_now, w_now;
	axil_aw_t              aw_cur;
	axil_w_t               w_cur;
	scr_req_t              wr_req, rd_req;
	logic [SCR_DATA_W-1:0] rdata_q;

	// Word index from address bits 5:2, wrapped to the depth
	function automatic logic [3:0] word_idx(input logic [AXIL_ADDR_W-1:0] addr);
		logic [3:0] idx;
		idx = '0;
		idx[IDX_W-1:0] = addr[IDX_W+1:2];
		return idx;
	endfunction

	assign aw_take = awvalid && awready;
	assign w_take  = wvalid && wready;
	assign ar_take = arvalid && arready;
	assign aw_now  = aw_held || aw_take;
	assign w_now   = w_held || w_take;
	assign aw_cur  = aw_take ? aw : aw_q;
	assign w_cur   = w_take ? w : w_q;

	assign wr_req = '{op: SCR_WRITE, idx: word_idx(aw_cur.addr),
		be: w_cur.strb[SCR_BE_W-1:0], wdata: w_cur.data[SCR_DATA_W-1:0]};
	assign rd_req = '{op: SCR_READ, idx: word_idx(ar.addr), be: '0, wdata: '0};

	assign b = '{resp: OKAY}; // Every aligned address decodes
	assign r = '{data: {{(32-SCR_DATA_W){1'b0}}, rdata_q}, resp: OKAY};

	////////////////////////////////////////
	// Transaction FSM
	////////////////////////////////////////

	always_ff @(posedge PORT_A_CLK) begin
		if (PORT_A_RD_ARST) begin
			state     <= IDLE;
			awready   <= 1'b0;
			wready    <= 1'b0;
			arready   <= 1'b0;
			aw_held   <= 1'b0;
			w_held    <= 1'b0;
			req_valid <= 1'b0;
			bvalid    <= 1'b0;
			rvalid    <= 1'b0;
		end else begin
			case (state)
				IDLE: begin
					if (aw_take) aw_held <= 1'b1;
					if (w_take) w_held <= 1'b1;
					if (ar_take) begin // Read goes ahead of a held write
						state     <= REQ_READ;
						req_valid <= 1'b1;
						awready   <= 1'b0;
						wready    <= 1'b0;
						arready   <= 1'b0;
					end else if (aw_now && w_now) begin
						aw_held <= 1'b0;
						w_held  <= 1'b0;
						awready <= 1'b0;
						wready  <= 1'b0;
						arready <= 1'b0;
						if (wr_req.be == '0) begin // Nothing to write
							state  <= WRITE_RESP;
							bvalid <= 1'b1;
						end else begin
							state     <= REQ_WRITE;
							req_valid <= 1'b1;
						end
					end else begin
						awready <= !aw_now;
						wready  <= !w_now;
						arready <= 1'b1;
					end
				end
				REQ_WRITE: if (gnt) begin
					state     <= WRITE_RESP;
					req_valid <= 1'b0;
					bvalid    <= 1'b1;
				end
				REQ_READ: if (gnt) begin
					state     <= READ_DATA;
					req_valid <= 1'b0;
				end
				READ_DATA: begin
					state  <= READ_RESP;
					rvalid <= 1'b1;
				end
				WRITE_RESP, READ_RESP: if ((bvalid && bready) || (rvalid && rready)) begin
					state   <= IDLE;
					bvalid  <= 1'b0;
					rvalid  <= 1'b0;
					awready <= !aw_held; // A write may still be held
					wready  <= !w_held;
					arready <= 1'b1;
				end
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge PORT_A_CLK) begin
		if (aw_take) aw_q <= aw;
		if (w_take) w_q <= w;
		if (state == IDLE) begin
			if (ar_take) req <= rd_req;
			else if (aw_now && w_now) req <= wr_req;
		end
		if (state == READ_DATA) rdata_q <= rd_data; // RAM output of the granted read
	end

	b_held: assert property (@(posedge PORT_A_CLK) disable iff (PORT_A_RD_ARST)
		bvalid && !bready |=> bvalid && $stable(b));

	r_held: assert property (@(posedge PORT_A_CLK) disable iff (PORT_A_RD_ARST)
		rvalid && !rready |=> rvalid && $stable(r));

	req_held: assert property (@(posedge PORT_A_CLK) disable iff (PORT_A_RD_ARST)
		req_valid && !gnt |=> req_valid && $stable(req));

endmodule

// ==== src/dual_port_scratch.sv ====
`timescale 1ns/1ps

module dual_port_scratch import axil_pkg::*, scratch_pkg::*; #(
	parameter int DEPTH = 16
) (
	input  logic     PORT_A_CLK,
	input  logic     PORT_A_RD_ARST,
	input  logic     s0_awvalid,
	output logic     s0_awready,
	input  axil_aw_t s0_aw,
	input  logic     s0_wvalid,
	output logic     s0_wready,
	input  axil_w_t  s0_w,
	output logic     s0_bvalid,
	input  logic     s0_bready,
	output axil_b_t  s0_b,
	input  logic     s0_arvalid,
	output logic     s0_arready,
	input  axil_ar_t s0_ar,
	output logic     s0_rvalid,
	input  logic     s0_rready,
	output axil_r_t  s0_r,
	input  logic     s1_awvalid,
	output logic     s1_awready,
	input  axil_aw_t s1_aw,
	input  logic     s1_wvalid,
	output logic     s1_wready,
	input  axil_w_t  s1_w,
	output logic     s1_bvalid,
	input  logic     s1_bready,
	output axil_b_t  s1_b,
	input  logic     s1_arvalid,
	output logic     s1_arready,
	input  axil_ar_t s1_ar,
	output logic     s1_rvalid,
	input  logic     s1_rready,
	output axil_r_t  s1_r
);

	logic [1:0]            req_valid;
	logic [1:0]            gnt;
	scr_req_t              req0, req1;
	logic                  mem_valid;
	scr_req_t              mem_req;
	logic [SCR_DATA_W-1:0] rd_data; // Shared by both ports

	axil_scratch_port #(.DEPTH(DEPTH)) u_port0 (
		.PORT_A_CLK, .PORT_A_RD_ARST,
		.awvalid(s0_awvalid), .awready(s0_awready), .aw(s0_aw),
		.wvalid(s0_wvalid), .wready(s0_wready), .w(s0_w),
		.bvalid(s0_bvalid), .bready(s0_bready), .b(s0_b),
		.arvalid(s0_arvalid), .arready(s0_arready), .ar(s0_ar),
		.rvalid(s0_rvalid), .rready(s0_rready), .r(s0_r),
		.req_valid(req_valid[0]), .req(req0), .gnt(gnt[0]), .rd_data
	);

	axil_scratch_port #(.DEPTH(DEPTH)) u_port1 (
		.PORT_A_CLK, .PORT_A_RD_ARST,
		.awvalid(s1_awvalid), .awready(s1_awready), .aw(s1_aw),
		.wvalid(s1_wvalid), .wready(s1_wready), .w(s1_w),
		.bvalid(s1_bvalid), .bready(s1_bready), .b(s1_b),
		.arvalid(s1_arvalid), .arready(s1_arready), .ar(s1_ar),
		.rvalid(s1_rvalid), .rready(s1_rready), .r(s1_r),
		.req_valid(req_valid[1]), .req(req1), .gnt(gnt[1]), .rd_data
	);

	scratch_arbiter u_arbiter (
		.PORT_A_CLK, .PORT_A_RD_ARST,
		.req_valid, .req0, .req1, .gnt, .mem_valid, .mem_req
	);

	scratch_ram #(.DEPTH(DEPTH)) u_ram (
		.PORT_A_CLK, .PORT_A_RD_ARST, .mem_valid, .mem_req, .rd_data
	);

endmodule

// ==== testbench/tb_dual_port_scratch.sv ====
`timescale 1ns/1ps

module tb_dual_port_scratch import axil_pkg::*, scratch_pkg::*; ();

	localparam int TIMEOUT = 20000; // About 400 transactions of up to 40 cycles, plus margin
	localparam bit WR = 1'b1;
	localparam bit RD = 1'b0;

	logic       PORT_A_CLK;
	logic       PORT_A_RD_ARST;
	logic [1:0] awvalid, awready, wvalid, wready, bvalid, bready;
	logic [1:0] arvalid, arready, rvalid, rready;
	axil_aw_t   aw [2];
	axil_w_t    w [2];
	axil_b_t    b [2];
	axil_ar_t   ar [2];
	axil_r_t    r [2];

	logic [SCR_DATA_W-1:0] shadow [16]; // Expected memory contents
	logic [3:0]            wr_idx [2], rd_idx [2], wr_strb [2];
	logic [31:0]           wr_data [2];
	int                    errors = 0;
	int                    cycles = 0;
	int                    done_cnt [2] = '{0, 0};
	bit                    count_en = 1'b0;
	bit                    stop = 1'b0;
	bit                    fair_check = 1'b0;

	dual_port_scratch #(.DEPTH(16)) uut (
		.PORT_A_CLK, .PORT_A_RD_ARST,
		.s0_awvalid(awvalid[0]), .s0_awready(awready[0]), .s0_aw(aw[0]),
		.s0_wvalid(wvalid[0]), .s0_wready(wready[0]), .s0_w(w[0]),
		.s0_bvalid(bvalid[0]), .s0_bready(bready[0]), .s0_b(b[0]),
		.s0_arvalid(arvalid[0]), .s0_arready(arready[0]), .s0_ar(ar[0]),
		.s0_rvalid(rvalid[0]), .s0_rready(rready[0]), .s0_r(r[0]),
		.s1_awvalid(awvalid[1]), .s1_awready(awready[1]), .s1_aw(aw[1]),
		.s1_wvalid(wvalid[1]), .s1_wready(wready[1]), .s1_w(w[1]),
		.s1_bvalid(bvalid[1]), .s1_bready(bready[1]), .s1_b(b[1]),
		.s1_arvalid(arvalid[1]), .s1_arready(arready[1]), .s1_ar(ar[1]),
		.s1_rvalid(rvalid[1]), .s1_rready(rready[1]), .s1_r(r[1])
	);

	// Byte lanes 0 and 1 follow the low two strobes
	function automatic logic [15:0] merge_bytes(input logic [15:0] old,
		input logic [15:0] data, input logic [1:0] strb);
		logic [15:0] res;
		res = old;
		if (strb[0]) res[7:0] = data[7:0];
		if (strb[1]) res[15:8] = data[15:8];
		return res;
	endfunction

	function automatic void note_error(input string msg);
		errors++;
		$display("error at %0t: %s", $time, msg);
	endfunction

	////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////

	task automatic transact(input bit p, input bit write, input logic [3:0] idx,
		input logic [31:0] data, input logic [3:0] strb, input bit bp);
		logic [2:0] taken;
		logic       hand;
		if (write) begin
			{wr_idx[p], wr_data[p], wr_strb[p]} = {idx, data, strb};
			aw[p] = '{addr: {idx, 2'b00}, prot: 3'b000};
			w[p] = '{data: data, strb: strb};
			{awvalid[p], wvalid[p]} = 2'b11;
		end else begin
			rd_idx[p] = idx;
			ar[p] = '{addr: {idx, 2'b00}, prot: 3'b000};
			arvalid[p] = 1'b1;
		end
		while (awvalid[p] || wvalid[p] || arvalid[p]) begin
			taken = {awready[p], wready[p], arready[p]};
			@(negedge PORT_A_CLK);
			if (taken[2]) awvalid[p] = 1'b0;
			if (taken[1]) wvalid[p] = 1'b0;
			if (taken[0]) arvalid[p] = 1'b0;
		end
		do begin
			{bready[p], rready[p]} = {2{!bp || ($urandom_range(0, 2) != 0)}}; // Random stalls
			hand = (bvalid[p] && bready[p]) || (rvalid[p] && rready[p]);
			@(negedge PORT_A_CLK);
		end while (!hand);
		{bready[p], rready[p]} = 2'b00;
	endtask

	// Each port stays in its own half of the memory
	task automatic random_traffic(input bit p, input bit bp);
		while (!stop) begin
			transact(p, 1'($urandom), {p, 3'($urandom)}, $urandom, 4'($urandom), bp);
		end
	endtask

	task automatic run_window(input bit bp, input int len);
		stop = 1'b0;
		fork
			random_traffic(1'b0, bp);
			random_traffic(1'b1, bp);
			begin
				repeat (len) @(negedge PORT_A_CLK);
				stop = 1'b1;
			end
		join
	endtask

	////////////////////////////////////////
	// Shadow memory and checks
	////////////////////////////////////////

	always @(posedge PORT_A_CLK) begin
		for (int p = 0; p < 2; p++) begin
			if (bvalid[p] && bready[p]) begin
				shadow[wr_idx[p]] <= merge_bytes(shadow[wr_idx[p]], wr_data[p][15:0],
					wr_strb[p][1:0]);
			end
			if (count_en && ((bvalid[p] && bready[p]) || (rvalid[p] && rready[p]))) begin
				done_cnt[p] <= done_cnt[p] + 1;
			end
		end
	end

	for (genvar p = 0; p < 2; p++) begin : g_check
		quiet_in_reset: assert property (@(posedge PORT_A_CLK) PORT_A_RD_ARST |=>
			!bvalid[p] && !rvalid[p] && !awready[p] && !wready[p] && !arready[p])
			else note_error("handshake output active during or right after reset");
		ready_after_reset: assert property (@(posedge PORT_A_CLK) $fell(PORT_A_RD_ARST) |=>
			awready[p] && wready[p] && arready[p])
			else note_error("address and data ready not raised once idle");
		write_okay: assert property (@(posedge PORT_A_CLK) disable iff (PORT_A_RD_ARST)
			bvalid[p] |-> b[p].resp == OKAY)
			else note_error("write response is not OKAY");
		read_match: assert property (@(posedge PORT_A_CLK) disable iff (PORT_A_RD_ARST)
			rvalid[p] && rready[p] |->
			r[p].data == {16'h0000, shadow[rd_idx[p]]} && r[p].resp == OKAY)
			else note_error("read data or response differs from the shadow memory");
		b_stable: assert property (@(posedge PORT_A_CLK) disable iff (PORT_A_RD_ARST)
			bvalid[p] && !bready[p] |=> bvalid[p] && $stable(b[p]))
			else note_error("write response dropped or changed before acceptance");
		r_stable: assert property (@(posedge PORT_A_CLK) disable iff (PORT_A_RD_ARST)
			rvalid[p] && !rready[p] |=> rvalid[p] && $stable(r[p]))
			else note_error("read response dropped or changed before acceptance");
	end

	no_starvation: assert property (@(posedge PORT_A_CLK)
		fair_check |-> done_cnt[0] >= 100 && done_cnt[1] >= 100)
		else note_error("a port completed fewer than 100 transactions under contention");

	initial begin
		PORT_A_CLK = 1'b0;
		forever #5 PORT_A_CLK = ~PORT_A_CLK;
	end

	initial begin
		while (cycles < TIMEOUT) begin
			@(posedge PORT_A_CLK);
			cycles++;
		end
		$display("The run did not finish within %0d cycles", TIMEOUT);
		$display("SOME TESTS FAILED");
		$finish;
	end

	initial begin
		void'($urandom(32'h3019));
		PORT_A_RD_ARST = 1'b1;
		{awvalid, wvalid, bready, arvalid, rready} = '0;
		for (int p = 0; p < 2; p++) begin
			aw[p] = '0;
			w[p] = '0;
			ar[p] = '0;
		end
		repeat (5) @(posedge PORT_A_CLK);
		@(negedge PORT_A_CLK);
		PORT_A_RD_ARST = 1'b0;
		fork // Known contents in every word
			for (int i = 0; i < 8; i++) transact(1'b0, WR, 4'(i), $urandom, 4'hf, 1'b0);
			for (int i = 8; i < 16; i++) transact(1'b1, WR, 4'(i), $urandom, 4'hf, 1'b0);
		join
		transact(1'b0, WR, 4'd3, 32'hdead_a5c3, 4'hf, 1'b0); // Upper half is dropped
		transact(1'b0, RD, 4'd3, '0, '0, 1'b0);
		transact(1'b0, WR, 4'd3, 32'h0000_7e00, 4'b0010, 1'b0); // High byte only
		transact(1'b0, RD, 4'd3, '0, '0, 1'b0);
		transact(1'b0, WR, 4'd10, 32'h0000_1234, 4'hf, 1'b0);
		transact(1'b1, RD, 4'd10, '0, '0, 1'b0); // Seen from the other port
		transact(1'b1, WR, 4'd5, 32'h0000_beef, 4'hf, 1'b0);
		transact(1'b0, RD, 4'd5, '0, '0, 1'b0);
		transact(1'b1, WR, 4'd5, 32'hffff_0000, 4'b1100, 1'b0); // No low strobes
		transact(1'b1, RD, 4'd5, '0, '0, 1'b0);
		run_window(1'b1, 1500); // Back-pressure on both ports
		count_en = 1'b1;
		run_window(1'b0, 1200);
		count_en = 1'b0;
		fair_check = 1'b1;
		@(negedge PORT_A_CLK);
		fair_check = 1'b0;
		repeat (2) @(negedge PORT_A_CLK);
		$display("errors %0d, port 0 transactions %0d, port 1 transactions %0d",
			errors, done_cnt[0], done_cnt[1]);
		if (errors == 0) $display("ALL TESTS PASSED");
		else $display("SOME TESTS FAILED");
		$finish;
	end

endmodule

// ==== dual_port_scratch.f ====
src/axil_pkg.sv
src/scratch_pkg.sv
src/scratch_ram.sv
src/scratch_arbiter.sv
src/axil_scratch_port.sv
src/dual_port_scratch.sv
testbench/tb_dual_port_scratch.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	--top-module tb_dual_port_scratch \
	-f dual_port_scratch.f \
	-o sim_dual_port_scratch

./obj_dir/sim_dual_port_scratch | tee sim.log

if grep -q "SOME TESTS FAILED" sim.log; then
	echo "Simulation failed"
	exit 1
fi
echo "Simulation passed"
